// ==== hdl/analog_pkg.sv ====
// Analog front end shared definitions
// Sample widths and the slow DAC (PWM) setting layout

package analog_pkg;

  //----------------------------------------
  // Fast ADC and DAC samples
  //----------------------------------------

  localparam int ADC_DW = 14;                // ADC and DAC sample width

  //----------------------------------------
  // Slow DAC setting word
  //----------------------------------------

  localparam int PWM_DW = 24;                // Full setting word
  localparam int PWM_CW = 8;                 // Coarse duty field
  localparam int PWM_BW = PWM_DW - PWM_CW;   // Dither field
  localparam int PWM_CH = 4;                 // Number of PWM outputs

  // Field view of one setting
  typedef struct packed {
    logic [PWM_CW-1:0] coarse;               // Level per PWM period
    logic [PWM_BW-1:0] dither;               // One extra count per set bit
  } pwm_fld_t;

  // Same 24 bits, seen by the bus as a flat word
  // and by the PWM generator as coarse/dither
  typedef union packed {
    logic [PWM_DW-1:0] word;                 // Register view
    pwm_fld_t          fld;                  // Generator view
  } pwm_word_u;

endpackage

// ==== hdl/wb_map_pkg.sv ====
// Wishbone register map of the analog front end
// Bus widths and byte offsets of all registers

package wb_map_pkg;

  //----------------------------------------
  // Bus widths
  //----------------------------------------

  localparam int WB_AW = 6;                  // Byte address
  localparam int WB_DW = 32;                 // Data word

  //----------------------------------------
  // Register offsets
  //----------------------------------------

  localparam logic [WB_AW-1:0] REG_ADC_A = 6'h00;  // RO, ADC A sample
  localparam logic [WB_AW-1:0] REG_ADC_B = 6'h04;  // RO, ADC B sample
  localparam logic [WB_AW-1:0] REG_DAC_A = 6'h08;  // RW, DAC A sample
  localparam logic [WB_AW-1:0] REG_DAC_B = 6'h0C;  // RW, DAC B sample
  localparam logic [WB_AW-1:0] REG_PWM_A = 6'h10;  // RW, slow DAC A
  localparam logic [WB_AW-1:0] REG_PWM_B = 6'h14;  // RW, slow DAC B
  localparam logic [WB_AW-1:0] REG_PWM_C = 6'h18;  // RW, slow DAC C
  localparam logic [WB_AW-1:0] REG_PWM_D = 6'h1C;  // RW, slow DAC D
  localparam logic [WB_AW-1:0] REG_FRAME = 6'h20;  // RO, PWM sync count

endpackage

// ==== hdl/adc_capture.sv ====
// Fast ADC capture
// Registers both raw channels and turns them into two's complement

module adc_capture
  import analog_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [ADC_DW-1:0] raw_a_i,         // Offset binary, negative slope
  input  logic [ADC_DW-1:0] raw_b_i,
  output logic [ADC_DW-1:0] adc_a_o,         // Two's complement
  output logic [ADC_DW-1:0] adc_b_o
);

  logic [ADC_DW-1:0] raw_a_q;                // Input registers
  logic [ADC_DW-1:0] raw_b_q;

  //----------------------------------------
  // Input registers
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= raw_a_i;                    // Sampled every cycle
      raw_b_q <= raw_b_i;
    end
  end

  //----------------------------------------
  // Format conversion
  //----------------------------------------

  // Inverting the magnitude bits flips the slope and
  // moves the offset-binary midpoint to zero
  assign adc_a_o = {raw_a_q[ADC_DW-1], ~raw_a_q[ADC_DW-2:0]};
  assign adc_b_o = {raw_b_q[ADC_DW-1], ~raw_b_q[ADC_DW-2:0]};

endmodule

// ==== hdl/dac_interleave.sv ====
// Fast DAC interleaver
// Converts both channels to offset binary and time-multiplexes
// A and B onto one data bus, marked by the select line

module dac_interleave
  import analog_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [ADC_DW-1:0] dac_a_i,         // Two's complement
  input  logic [ADC_DW-1:0] dac_b_i,
  output logic [ADC_DW-1:0] dac_dat_o,       // Offset binary, negative slope
  output logic              dac_sel_o,       // High while A on the bus
  output logic              dac_rst_o        // DAC chip reset
);

  logic [ADC_DW-1:0] dac_a_q;                // Converted A
  logic [ADC_DW-1:0] dac_b_q;                // Converted B
  logic [ADC_DW-1:0] dat_q;                  // Bus register
  logic              sel_q;                  // Channel toggle
  logic              chip_rst_q;             // Reset line to the chip

  //----------------------------------------
  // Sample conversion
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    dac_a_q <= {dac_a_i[ADC_DW-1], ~dac_a_i[ADC_DW-2:0]};  // Signed to unsigned
    dac_b_q <= {dac_b_i[ADC_DW-1], ~dac_b_i[ADC_DW-2:0]};  // Negative slope too
  end

  //----------------------------------------
  // Bus multiplexer
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      chip_rst_q <= 1'b1;                    // Held through reset
      sel_q      <= 1'b0;
      dat_q      <= '0;
    end else begin
      chip_rst_q <= 1'b0;                    // One cycle after release
      if (chip_rst_q) begin
        sel_q <= 1'b0;                       // Bus quiet during chip reset
        dat_q <= '0;
      end else begin
        sel_q <= ~sel_q;
        // Pick the channel that matches the new select value
        dat_q <= sel_q ? dac_b_q : dac_a_q;
      end
    end
  end

  assign dac_dat_o = dat_q;
  assign dac_sel_o = sel_q;
  assign dac_rst_o = chip_rst_q;

endmodule

// ==== hdl/pwm_dac.sv ====
// Slow DAC, four dithered PWM outputs
// Coarse level per period plus one count per dither bit,
// new settings taken every 16 periods with a sync pulse just before

module pwm_dac
  import analog_pkg::*;
#(
  parameter int unsigned PWM_FULL = 156      // Counter value at 100 % duty
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  pwm_word_u [PWM_CH-1:0] pwm_set_i,  // Settings from the register block
  output logic      [PWM_CH-1:0] pwm_o,      // To the RC filters
  output logic                   pwm_sync_o  // One cycle before settings latch
);

  localparam logic [PWM_CW-1:0] V_FULL = PWM_FULL[PWM_CW-1:0];  // Last count
  localparam logic [PWM_CW-1:0] V_SYNC = V_FULL - 1'b1;         // Sync count

  logic [PWM_CW-1:0] vcnt;                   // Period counter, 1 to V_FULL
  logic [PWM_CW-1:0] vcnt_r;                 // Delayed for the compare stage
  logic [3:0]        bcnt;                   // Periods in frame
  logic [PWM_CW-1:0] coarse [PWM_CH];        // Latched coarse level
  logic [PWM_BW-1:0] dither [PWM_CH];        // Latched dither, shifted
  logic [PWM_CW-1:0] lvl_r  [PWM_CH];        // Level for this period
  logic [PWM_CH-1:0] pwm_r;                  // Compare result
  logic [PWM_CH-1:0] pwm_q;                  // Output register
  logic              period_end;
  logic              frame_end;

  assign period_end = (vcnt == V_FULL);
  assign frame_end  = period_end && (bcnt == 4'hF);

  //----------------------------------------
  // Period and frame counters
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vcnt <= V_FULL;                        // Start as if at period end
      bcnt <= 4'h0;
    end else begin
      vcnt <= period_end ? PWM_CW'(1) : vcnt + 1'b1;
      if (period_end) begin
        bcnt <= bcnt + 4'h1;                 // Wraps after 16 periods
      end
    end
  end

  //----------------------------------------
  // Settings latch and dither shift
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < PWM_CH; i++) begin
        coarse[i] <= '0;
        dither[i] <= '0;
      end
    end else begin
      for (int i = 0; i < PWM_CH; i++) begin
        if (frame_end) begin
          coarse[i] <= pwm_set_i[i].fld.coarse;  // New value every 16 periods
          dither[i] <= pwm_set_i[i].fld.dither;
        end else if (period_end) begin
          dither[i] <= dither[i] >> 1;       // Next dither bit
        end
      end
    end
  end

  //----------------------------------------
  // Duty pipeline
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vcnt_r <= V_FULL;                      // Above any reset level
      pwm_r  <= '0;
      pwm_q  <= '0;
      for (int i = 0; i < PWM_CH; i++) begin
        lvl_r[i] <= '0;
      end
    end else begin
      vcnt_r <= vcnt;
      for (int i = 0; i < PWM_CH; i++) begin
        lvl_r[i] <= coarse[i] + PWM_CW'(dither[i][0]);  // Coarse plus dither bit
        pwm_r[i] <= (vcnt_r <= lvl_r[i]);    // High up to the level
      end
      pwm_q <= pwm_r;                        // Retimed output
    end
  end

  assign pwm_o      = pwm_q;
  assign pwm_sync_o = (bcnt == 4'hF) && (vcnt == V_SYNC);  // Last period, one early

endmodule

// ==== hdl/analog_regs.sv ====
// Analog front end register block
// Wishbone classic slave with DAC and PWM settings,
// ADC sample read-back and a PWM frame counter

module analog_regs
  import analog_pkg::*;
  import wb_map_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Wishbone slave
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [WB_AW-1:0]       wb_adr_i,   // Byte address
  input  logic [WB_DW-1:0]       wb_dat_i,
  output logic [WB_DW-1:0]       wb_dat_o,
  output logic                   wb_ack_o,
  // Status in
  input  logic [ADC_DW-1:0]      adc_a_i,    // Two's complement
  input  logic [ADC_DW-1:0]      adc_b_i,
  input  logic                   pwm_sync_i, // Frame sync from the PWM
  // Settings out
  output logic [ADC_DW-1:0]      dac_a_o,
  output logic [ADC_DW-1:0]      dac_b_o,
  output pwm_word_u [PWM_CH-1:0] pwm_set_o
);

  localparam int FRAME_W = 16;               // Sync counter width

  logic               req;                   // Accepted request this cycle
  logic [FRAME_W-1:0] frame_q;               // Sync pulse count
  logic [WB_DW-1:0]   rd_dat;                // Read mux

  // No new request in the ack cycle, so a held stb is acked once
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o;

  //----------------------------------------
  // Ack and write decode
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_ack_o  <= 1'b0;
      dac_a_o   <= '0;
      dac_b_o   <= '0;
      pwm_set_o <= '0;
    end else begin
      wb_ack_o <= req;                       // Single-cycle registered ack
      if (req && wb_we_i) begin
        case (wb_adr_i)
          REG_DAC_A: dac_a_o <= wb_dat_i[ADC_DW-1:0];
          REG_DAC_B: dac_b_o <= wb_dat_i[ADC_DW-1:0];
          REG_PWM_A: pwm_set_o[0].word <= wb_dat_i[PWM_DW-1:0];
          REG_PWM_B: pwm_set_o[1].word <= wb_dat_i[PWM_DW-1:0];
          REG_PWM_C: pwm_set_o[2].word <= wb_dat_i[PWM_DW-1:0];
          REG_PWM_D: pwm_set_o[3].word <= wb_dat_i[PWM_DW-1:0];
          default: ;                         // Read-only or unmapped
        endcase
      end
    end
  end

  //----------------------------------------
  // Read path
  //----------------------------------------

  always_comb begin
    rd_dat = '0;                             // Unmapped reads zero
    case (wb_adr_i)
      REG_ADC_A: rd_dat = {{(WB_DW-ADC_DW){adc_a_i[ADC_DW-1]}}, adc_a_i};  // Sign ext
      REG_ADC_B: rd_dat = {{(WB_DW-ADC_DW){adc_b_i[ADC_DW-1]}}, adc_b_i};
      REG_DAC_A: rd_dat = WB_DW'(dac_a_o);
      REG_DAC_B: rd_dat = WB_DW'(dac_b_o);
      REG_PWM_A: rd_dat = WB_DW'(pwm_set_o[0].word);
      REG_PWM_B: rd_dat = WB_DW'(pwm_set_o[1].word);
      REG_PWM_C: rd_dat = WB_DW'(pwm_set_o[2].word);
      REG_PWM_D: rd_dat = WB_DW'(pwm_set_o[3].word);
      REG_FRAME: rd_dat = WB_DW'(frame_q);
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_dat_o <= '0;
    end else if (req && !wb_we_i) begin
      wb_dat_o <= rd_dat;                    // Valid with ack
    end
  end

  //----------------------------------------
  // Frame counter
  //----------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      frame_q <= '0;
    end else if (pwm_sync_i) begin
      frame_q <= frame_q + 1'b1;             // Wraps at 16 bits
    end
  end

endmodule

// ==== hdl/analog_top.sv ====
// Analog front end top level
// ADC capture, DAC interleaver and PWM slow DAC behind one
// Wishbone register block, all on adc_clk

module analog_top
  import analog_pkg::*;
  import wb_map_pkg::*;
#(
  parameter int unsigned PWM_FULL = 156      // PWM counter at 100 % duty
) (
  input  logic              adc_clk,
  input  logic              dac_rst,         // Sync, active high
  // Wishbone slave
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [WB_AW-1:0]  wb_adr_i,
  input  logic [WB_DW-1:0]  wb_dat_i,
  output logic [WB_DW-1:0]  wb_dat_o,
  output logic              wb_ack_o,
  // ADC chip
  input  logic [ADC_DW-1:0] adc_dat_a_i,
  input  logic [ADC_DW-1:0] adc_dat_b_i,
  // DAC chip
  output logic [ADC_DW-1:0] dac_dat_o,
  output logic              dac_sel_o,
  output logic              dac_rst_o,
  // Slow DAC
  output logic [PWM_CH-1:0] dac_pwm_o,
  output logic              dac_pwm_sync_o
);

  logic [ADC_DW-1:0]      adc_a;             // Converted ADC samples
  logic [ADC_DW-1:0]      adc_b;
  logic [ADC_DW-1:0]      dac_a;             // DAC settings
  logic [ADC_DW-1:0]      dac_b;
  pwm_word_u [PWM_CH-1:0] pwm_set;           // PWM settings
  logic                   pwm_sync;

  //----------------------------------------
  // Datapath blocks
  //----------------------------------------

  adc_capture u_adc_capture (
    .clk_i   (adc_clk),
    .rst_i   (dac_rst),
    .raw_a_i (adc_dat_a_i),
    .raw_b_i (adc_dat_b_i),
    .adc_a_o (adc_a),
    .adc_b_o (adc_b)
  );

  pwm_dac #(
    .PWM_FULL (PWM_FULL)
  ) u_pwm_dac (
    .clk_i      (adc_clk),
    .rst_i      (dac_rst),
    .pwm_set_i  (pwm_set),
    .pwm_o      (dac_pwm_o),
    .pwm_sync_o (pwm_sync)
  );

  dac_interleave u_dac_interleave (
    .clk_i     (adc_clk),
    .rst_i     (dac_rst),
    .dac_a_i   (dac_a),
    .dac_b_i   (dac_b),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_rst_o (dac_rst_o)
  );

  //----------------------------------------
  // Register block
  //----------------------------------------

  analog_regs u_analog_regs (
    .clk_i      (adc_clk),
    .rst_i      (dac_rst),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .adc_a_i    (adc_a),
    .adc_b_i    (adc_b),
    .pwm_sync_i (pwm_sync),
    .dac_a_o    (dac_a),
    .dac_b_o    (dac_b),
    .pwm_set_o  (pwm_set)
  );

  assign dac_pwm_sync_o = pwm_sync;          // Also seen by the frame counter

endmodule

// ==== bench/tb_analog.sv ====
// Testbench for the analog front end
// Directed tests over Wishbone, the ADC inputs, the DAC bus and the PWM outputs

module tb_analog
  import analog_pkg::*;
  import wb_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned FULL         = 10;           // Short PWM period
  localparam int          ACK_TIMEOUT  = 20;           // Cycles per bus transfer
  localparam int          SYNC_TIMEOUT = 2 * 16 * FULL; // Two frames

  logic              adc_clk = 1'b0;
  logic              dac_rst;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [WB_AW-1:0]  wb_adr;
  logic [WB_DW-1:0]  wb_dat_w;
  logic [WB_DW-1:0]  wb_dat_r;
  logic              wb_ack;
  logic [ADC_DW-1:0] adc_a;
  logic [ADC_DW-1:0] adc_b;
  logic [ADC_DW-1:0] dac_dat_o;
  logic              dac_sel_o;
  logic              dac_rst_o;
  logic [PWM_CH-1:0] dac_pwm_o;
  logic              dac_pwm_sync_o;

  int                errors      = 0;
  int                start_errors = 0;
  int                tests_run   = 0;
  int                syncs_seen  = 0;                  // Sync pulses since reset
  string             cur_test    = "init";
  logic [ADC_DW-1:0] dac_a_set;                        // Last written DAC values
  logic [ADC_DW-1:0] dac_b_set;
  logic [WB_DW-1:0]  pwm_set [PWM_CH];                 // Last written PWM words

  analog_top #(
    .PWM_FULL (FULL)
  ) u_analog_top (
    .adc_clk        (adc_clk),
    .dac_rst        (dac_rst),
    .wb_cyc_i       (wb_cyc),
    .wb_stb_i       (wb_stb),
    .wb_we_i        (wb_we),
    .wb_adr_i       (wb_adr),
    .wb_dat_i       (wb_dat_w),
    .wb_dat_o       (wb_dat_r),
    .wb_ack_o       (wb_ack),
    .adc_dat_a_i    (adc_a),
    .adc_dat_b_i    (adc_b),
    .dac_dat_o      (dac_dat_o),
    .dac_sel_o      (dac_sel_o),
    .dac_rst_o      (dac_rst_o),
    .dac_pwm_o      (dac_pwm_o),
    .dac_pwm_sync_o (dac_pwm_sync_o)
  );

  always #50 adc_clk = ~adc_clk;                       // 100 ns period

  //----------------------------------------
  // Helpers
  //----------------------------------------

  // One cycle up to the drive and sample point
  task automatic step();
    @(posedge adc_clk);
    #5;
    if (!dac_rst && dac_pwm_sync_o) begin
      syncs_seen++;                                    // Every cycle passes here once
    end
  endtask

  task automatic check(input string what, input logic [WB_DW-1:0] exp,
                       input logic [WB_DW-1:0] act);
    if (act !== exp) begin
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  // Negative slope around mid-scale code 8191
  function automatic logic [WB_DW-1:0] adc_expect(input logic [ADC_DW-1:0] raw);
    return WB_DW'(8191 - int'(raw));
  endfunction

  function automatic logic [ADC_DW-1:0] dac_expect(input logic [ADC_DW-1:0] val);
    return ADC_DW'(8191 - int'(signed'(val)));
  endfunction

  task automatic begin_test(input string name);
    cur_test     = name;
    start_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == start_errors) begin
      $display("test %-8s ok", cur_test);
    end else begin
      $display("test %-8s failed with %0d errors", cur_test, errors - start_errors);
    end
  endtask

  task automatic wb_xfer(input logic we, input logic [WB_AW-1:0] adr,
                         input logic [WB_DW-1:0] dat, output logic [WB_DW-1:0] rd);
    int   n;
    logic busy;                                        // Previous ack still high
    busy     = wb_ack;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    n = 0;
    step();
    while (!wb_ack && n < ACK_TIMEOUT) begin
      step();
      n++;
    end
    if (!wb_ack) begin
      $display("%s: no ack from the slave at address %h", cur_test, adr);
      errors++;
    end else begin
      // Held stb is ignored for one cycle after an ack
      check("ack latency", busy ? 32'd1 : 32'd0, WB_DW'(n));
    end
    rd     = wb_dat_r;                                 // Valid in the ack cycle
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
    logic [WB_DW-1:0] unused;
    wb_xfer(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rd);
    wb_xfer(1'b0, adr, '0, rd);
  endtask

  task automatic wait_sync();
    int n;
    n = 0;
    step();
    while (!dac_pwm_sync_o && n < SYNC_TIMEOUT) begin
      step();
      n++;
    end
    if (!dac_pwm_sync_o) begin
      $display("%s: no PWM sync pulse within %0d cycles", cur_test, SYNC_TIMEOUT);
      errors++;
    end
  endtask

  //----------------------------------------
  // Tests
  //----------------------------------------

  task automatic reset_values();
    int               rst_seen;
    logic [WB_DW-1:0] rd;
    begin_test("reset");
    rst_seen = 0;
    for (int i = 0; i < 6; i++) begin
      rst_seen += int'(dac_rst_o);
      if (i < 2) begin                                 // Bus quiet until toggling starts
        check("dac_sel", 32'd0, WB_DW'(dac_sel_o));
        check("dac_dat", 32'd0, WB_DW'(dac_dat_o));
      end
      check("dac_pwm", 32'd0, WB_DW'(dac_pwm_o));
      step();
    end
    check("dac_rst_o high cycles", 32'd1, WB_DW'(rst_seen));
    for (int a = 0; a <= 32; a += 4) begin
      wb_read(WB_AW'(a), rd);
      check($sformatf("reg %h", a), 32'd0, rd);
    end
    end_test();
  endtask

  task automatic adc_readback();
    logic [WB_DW-1:0] rd;
    begin_test("adc");
    for (int i = 0; i < 4; i++) begin
      adc_a = ADC_DW'($urandom);
      adc_b = ADC_DW'($urandom);
      repeat (2) step();
      wb_read(REG_ADC_A, rd);
      check("adc_a", adc_expect(adc_a), rd);
      wb_read(REG_ADC_B, rd);
      check("adc_b", adc_expect(adc_b), rd);
    end
    end_test();
  endtask

  task automatic dac_bus();
    logic [WB_DW-1:0] rd;
    logic             prev_sel;                        // Select seen one cycle earlier
    begin_test("dac");
    dac_a_set = ADC_DW'($urandom);
    dac_b_set = ADC_DW'($urandom);
    wb_write(REG_DAC_A, WB_DW'(dac_a_set));
    wb_write(REG_DAC_B, WB_DW'(dac_b_set));
    repeat (4) step();                                 // Bus updated within 3 cycles
    for (int i = 0; i < 8; i++) begin
      if (i > 0) begin
        check("sel toggle", WB_DW'(!prev_sel), WB_DW'(dac_sel_o));
      end
      prev_sel = dac_sel_o;
      if (dac_sel_o) begin
        check("bus A", WB_DW'(dac_expect(dac_a_set)), WB_DW'(dac_dat_o));
      end else begin
        check("bus B", WB_DW'(dac_expect(dac_b_set)), WB_DW'(dac_dat_o));
      end
      step();
    end
    wb_read(REG_DAC_A, rd);
    check("read dac_a", WB_DW'(dac_a_set), rd);
    wb_read(REG_DAC_B, rd);
    check("read dac_b", WB_DW'(dac_b_set), rd);
    end_test();
  endtask

  task automatic pwm_duty();
    logic [PWM_CW-1:0] coarse;
    logic [PWM_BW-1:0] dither;
    int                hi_exp [PWM_CH];
    int                hi_cnt [PWM_CH];
    begin_test("pwm");
    for (int ch = 0; ch < PWM_CH; ch++) begin
      coarse      = PWM_CW'($urandom_range(FULL - 1, 0));
      dither      = PWM_BW'($urandom);
      pwm_set[ch] = {8'h00, coarse, dither};
      hi_exp[ch]  = 16 * int'(coarse) + $countones(dither);
      hi_cnt[ch]  = 0;
      wb_write(REG_PWM_A + WB_AW'(4 * ch), pwm_set[ch]);
    end
    wait_sync();
    wait_sync();                                       // Whole frame on new settings
    repeat (4) step();
    for (int i = 0; i < 16 * FULL; i++) begin
      step();                                          // First sample 5 cycles after sync
      for (int ch = 0; ch < PWM_CH; ch++) begin
        hi_cnt[ch] += int'(dac_pwm_o[ch]);
      end
    end
    for (int ch = 0; ch < PWM_CH; ch++) begin
      check($sformatf("high count ch%0d", ch), WB_DW'(hi_exp[ch]), WB_DW'(hi_cnt[ch]));
    end
    end_test();
  endtask

  task automatic frame_count();
    int               exp;
    logic [WB_DW-1:0] rd;
    begin_test("frame");
    wait_sync();
    wait_sync();
    step();                                            // Last pulse reaches the counter
    exp = syncs_seen;
    wb_read(REG_FRAME, rd);
    check("frame count", WB_DW'(exp), rd);
    end_test();
  endtask

  task automatic unmapped_access();
    logic [WB_DW-1:0] rd;
    begin_test("unmapped");
    wb_read(6'h3C, rd);
    check("read 0x3C", 32'd0, rd);
    wb_write(6'h3C, $urandom);
    wb_read(REG_DAC_A, rd);
    check("dac_a kept", WB_DW'(dac_a_set), rd);
    wb_read(REG_DAC_B, rd);
    check("dac_b kept", WB_DW'(dac_b_set), rd);
    for (int ch = 0; ch < PWM_CH; ch++) begin
      wb_read(REG_PWM_A + WB_AW'(4 * ch), rd);
      check($sformatf("pwm ch%0d kept", ch), pwm_set[ch], rd);
    end
    end_test();
  endtask

  //----------------------------------------
  // Sequence
  //----------------------------------------

  initial begin
    dac_rst  = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    adc_a    = 14'h1FFF;                               // Mid-scale reads as zero
    adc_b    = 14'h1FFF;
    void'($urandom(32'h7cef));
    repeat (3) step();
    dac_rst = 1'b0;
    reset_values();
    adc_readback();
    dac_bus();
    pwm_duty();
    frame_count();
    unmapped_access();
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hdl/analog_pkg.sv
hdl/wb_map_pkg.sv
hdl/adc_capture.sv
hdl/dac_interleave.sv
hdl/pwm_dac.sv
hdl/analog_regs.sv
hdl/analog_top.sv
bench/tb_analog.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_analog
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
